// File: source/spw_tx_cfg.svh
/* Character lengths count the parity and flag bits. Count widths are sized
   for the SpaceWire credit limit of 56 and at most 7 owed FCTs */
`ifndef SPW_TX_CFG_SVH
`define SPW_TX_CFG_SVH

// Character lengths in bits
`define SPW_LEN_CTRL 4
`define SPW_LEN_NULL 8
`define SPW_LEN_DATA 10
`define SPW_LEN_TIME 14

// Flow control, one received FCT grants eight N-chars
`define SPW_CREDIT_STEP 8
`define SPW_CREDIT_MAX 56
`define SPW_CREDIT_W 6

// Owed FCTs after reset
`define SPW_FCT_INIT 1
`define SPW_OWED_W 3

`endif

// File: source/spw_tx_pkg.sv
/* Control codes go out least significant bit first. The user's end code
   is 0 for EOP and anything else for EEP */
`default_nettype none

package spw_tx_pkg;

	typedef enum logic [2:0] {
		K_NULL,
		K_FCT,
		K_EOP,
		K_EEP,
		K_DATA,
		K_TIME
	} char_kind_e;

	typedef enum logic [1:0] {
		LS_IDLE,
		LS_NULL,
		LS_NULL_FCT,
		LS_RUN
	} link_state_e;

	// N-char word as written by the user
	typedef struct packed {
		logic       flag;
		logic [7:0] value;
	} nchar_data_t;

	typedef struct packed {
		logic       flag;
		logic [5:0] pad;
		logic [1:0] code;
	} nchar_ctrl_t;

	typedef union packed {
		nchar_data_t data;
		nchar_ctrl_t ctrl;
	} nchar_u;

	localparam logic [1:0] CODE_FCT = 2'b00;
	localparam logic [1:0] CODE_EOP = 2'b01;
	localparam logic [1:0] CODE_EEP = 2'b10;
	localparam logic [1:0] CODE_ESC = 2'b11;

endpackage

`default_nettype wire

// File: source/spw_char_if.sv
/* One character per load. need and load meet in the same cycle, so the
   serializer never waits for the scheduler */
`timescale 1ns/1ps
`default_nettype none

interface spw_char_if;

	spw_tx_pkg::char_kind_e kind;
	logic [8:0]             word;
	logic                   load;
	logic                   need;

	modport sched (
		output kind,
		output word,
		output load,
		input  need
	);

	// Serializer side
	modport ser (
		input  kind,
		input  word,
		input  load,
		output need
	);

endinterface

`default_nettype wire

// File: source/spw_tx_sched.sv
/* txwrite_i and tickin_i are held with stable data until their accept pulse.
   gotfct_i and fct_req_i count once per cycle in which they are high */
`timescale 1ns/1ps
`default_nettype none
`include "spw_tx_cfg.svh"

module spw_tx_sched (
	input  wire                     pclk_tx,
	input  wire                     enable_tx,
	input  wire                     send_null_i,
	input  wire                     send_fct_i,
	input  wire                     gotfct_i,
	input  wire                     fct_req_i,
	input  wire                     txwrite_i,
	input  wire spw_tx_pkg::nchar_u data_i,
	input  wire                     tickin_i,
	input  wire [7:0]               time_i,
	output logic                    data_ack_o,
	output logic                    time_ack_o,
	spw_char_if.sched               ch
);

	spw_tx_pkg::link_state_e  state_q;
	spw_tx_pkg::link_state_e  state_d;
	logic [`SPW_CREDIT_W-1:0] credit_q;
	logic [`SPW_CREDIT_W:0]   credit_sum;
	logic [`SPW_OWED_W-1:0]   owed_q;
	logic                     fct_ld;

	// --------------------------------------------------------------------------
	// Link sequence
	always_comb
	begin
		state_d = state_q;
		case (state_q)
		spw_tx_pkg::LS_IDLE:     if (send_null_i) state_d = spw_tx_pkg::LS_NULL;
		spw_tx_pkg::LS_NULL:     if (send_fct_i) state_d = spw_tx_pkg::LS_NULL_FCT;
		spw_tx_pkg::LS_NULL_FCT: if (gotfct_i) state_d = spw_tx_pkg::LS_RUN;
		default:                 state_d = state_q;
		endcase
	end

	// --------------------------------------------------------------------------
	// Next character, chosen whenever the serializer asks
	always_comb
	begin
		ch.kind = spw_tx_pkg::K_NULL;
		ch.word = '0;
		ch.load = ch.need && (state_q != spw_tx_pkg::LS_IDLE);
		if (state_q == spw_tx_pkg::LS_NULL_FCT && owed_q != '0)
			ch.kind = spw_tx_pkg::K_FCT;
		else if (state_q == spw_tx_pkg::LS_RUN)
		begin
			if (tickin_i)
			begin
				ch.kind = spw_tx_pkg::K_TIME;
				ch.word = {1'b0, time_i};
			end
			else if (owed_q != '0)
				ch.kind = spw_tx_pkg::K_FCT;
			else if (txwrite_i && credit_q != '0)
			begin
				if (data_i.ctrl.flag)
				begin
					ch.word = data_i;
					if (data_i.ctrl.code == 2'd0)
						ch.kind = spw_tx_pkg::K_EOP;
					else
						ch.kind = spw_tx_pkg::K_EEP;
				end
				else
				begin
					ch.kind = spw_tx_pkg::K_DATA;
					ch.word = {1'b0, data_i.data.value};
				end
			end
		end
	end

	assign time_ack_o = ch.load && (ch.kind == spw_tx_pkg::K_TIME);
	assign fct_ld = ch.load && (ch.kind == spw_tx_pkg::K_FCT);
	assign data_ack_o = ch.load && (ch.kind == spw_tx_pkg::K_DATA ||
		ch.kind == spw_tx_pkg::K_EOP || ch.kind == spw_tx_pkg::K_EEP);

	// Credit saturates before the N-char of the same cycle is taken off
	always_comb
	begin
		credit_sum = {1'b0, credit_q};
		if (gotfct_i)
		begin
			credit_sum = credit_sum + (`SPW_CREDIT_W + 1)'(`SPW_CREDIT_STEP);
			if (credit_sum > (`SPW_CREDIT_W + 1)'(`SPW_CREDIT_MAX))
				credit_sum = (`SPW_CREDIT_W + 1)'(`SPW_CREDIT_MAX);
		end
		if (data_ack_o)
			credit_sum = credit_sum - 1'b1;
	end

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state_q  <= spw_tx_pkg::LS_IDLE;
			credit_q <= '0;
			owed_q   <= `SPW_OWED_W'(`SPW_FCT_INIT);
		end
		else
		begin
			state_q  <= state_d;
			credit_q <= credit_sum[`SPW_CREDIT_W-1:0];
			owed_q   <= owed_q + `SPW_OWED_W'(fct_req_i) - `SPW_OWED_W'(fct_ld);
		end
	end

endmodule

`default_nettype wire

// File: source/spw_tx_serializer.sv
/* One bit per pclk_tx cycle, least significant first. The first parity bit
   after reset is taken against a previous payload of zero */
`timescale 1ns/1ps
`default_nettype none
`include "spw_tx_cfg.svh"

module spw_tx_serializer (
	input  wire     pclk_tx,
	input  wire     enable_tx,
	spw_char_if.ser ch,
	output logic    d_o,
	output logic    s_o
);

	logic [13:0] vec;
	logic [12:0] sr_q;
	logic [3:0]  cnt_q;
	logic [3:0]  len;
	logic [1:0]  code;
	logic        first_flag;
	logic        p1;
	logic        pay_par;
	logic        par_q;
	logic        take;
	logic        nb;

	// --------------------------------------------------------------------------
	// Character build, bit 0 leaves first
	always_comb
	begin
		first_flag = (ch.kind != spw_tx_pkg::K_DATA);
		p1 = ~(par_q ^ first_flag);
		case (ch.kind)
		spw_tx_pkg::K_EOP: code = spw_tx_pkg::CODE_EOP;
		spw_tx_pkg::K_EEP: code = spw_tx_pkg::CODE_EEP;
		default:           code = spw_tx_pkg::CODE_FCT;
		endcase

		vec = {10'b0, code[1], code[0], 1'b1, p1};
		len = 4'(`SPW_LEN_CTRL);
		pay_par = ^code;
		case (ch.kind)
		spw_tx_pkg::K_NULL:
		begin
			// ESC then FCT, inner parity covers the ESC code
			vec = {6'b0, code[1], code[0], 1'b1, ~(^spw_tx_pkg::CODE_ESC ^ 1'b1),
				spw_tx_pkg::CODE_ESC[1], spw_tx_pkg::CODE_ESC[0], 1'b1, p1};
			len = 4'(`SPW_LEN_NULL);
		end
		spw_tx_pkg::K_DATA:
		begin
			vec = {4'b0, ch.word[7:0], 1'b0, p1};
			len = 4'(`SPW_LEN_DATA);
			pay_par = ^ch.word[7:0];
		end
		spw_tx_pkg::K_TIME:
		begin
			vec = {ch.word[7:0], 1'b0, ~(^spw_tx_pkg::CODE_ESC),
				spw_tx_pkg::CODE_ESC[1], spw_tx_pkg::CODE_ESC[0], 1'b1, p1};
			len = 4'(`SPW_LEN_TIME);
			pay_par = ^ch.word[7:0];
		end
		default:
		begin
			len = 4'(`SPW_LEN_CTRL);
		end
		endcase
	end

	// Last bit on the line or nothing loaded
	assign ch.need = (cnt_q == 4'd0);
	assign take = ch.need && ch.load;
	assign nb = take ? vec[0] : sr_q[0];

	// --------------------------------------------------------------------------
	// DS encoder and bit count
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			d_o   <= 1'b0;
			s_o   <= 1'b0;
			cnt_q <= 4'd0;
			par_q <= 1'b0;
		end
		else
		begin
			if (take || cnt_q != 4'd0)
			begin
				d_o <= nb;
				s_o <= s_o ^ (nb == d_o);
			end
			if (take)
			begin
				cnt_q <= len - 4'd1;
				par_q <= pay_par;
			end
			else if (cnt_q != 4'd0)
				cnt_q <= cnt_q - 4'd1;
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (take)
			sr_q <= vec[13:1];
		else
			sr_q <= {1'b0, sr_q[12:1]};
	end

endmodule

`default_nettype wire

// File: source/spw_tx.sv
/* SpaceWire transmitter on a single clock. Outputs stay low while enable_tx
   is low and until send_null_i starts the link */
`timescale 1ns/1ps
`default_nettype none

module spw_tx (
	input  wire                     pclk_tx,
	input  wire                     enable_tx,
	input  wire                     send_null_i,
	input  wire                     send_fct_i,
	input  wire                     gotfct_i,
	input  wire                     fct_req_i,
	input  wire                     txwrite_i,
	input  wire spw_tx_pkg::nchar_u data_i,
	input  wire                     tickin_i,
	input  wire [7:0]               time_i,
	output wire                     d_o,
	output wire                     s_o,
	output wire                     data_ack_o,
	output wire                     time_ack_o
);

	spw_char_if i_char_if ();

	// Character scheduler
	spw_tx_sched i_sched (
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.send_null_i (send_null_i),
		.send_fct_i  (send_fct_i),
		.gotfct_i    (gotfct_i),
		.fct_req_i   (fct_req_i),
		.txwrite_i   (txwrite_i),
		.data_i      (data_i),
		.tickin_i    (tickin_i),
		.time_i      (time_i),
		.data_ack_o  (data_ack_o),
		.time_ack_o  (time_ack_o),
		.ch          (i_char_if.sched)
	);

	// Serializer and DS pair
	spw_tx_serializer i_ser (
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.ch        (i_char_if.ser),
		.d_o       (d_o),
		.s_o       (s_o)
	);

endmodule

`default_nettype wire

// File: tb/spw_tx_sva.sv
/* Checked from the first bit on the line, all rules are off while
   enable_tx is low */
`timescale 1ns/1ps
`default_nettype none

module spw_tx_sva (
	input wire pclk_tx,
	input wire enable_tx,
	input wire d_i,
	input wire s_i,
	input wire data_ack_i,
	input wire time_ack_i
);

	logic live_q;

	// Line is live once either DS wire has left zero
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
			live_q <= 1'b0;
		else if (d_i || s_i)
			live_q <= 1'b1;
	end

	ds_one_change: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		live_q |-> ((d_i ^ s_i) != $past(d_i ^ s_i)))
		else $error("d_o and s_o did not change by exactly one wire");

	acks_exclusive: assert property (@(posedge pclk_tx) disable iff (!enable_tx)
		!(data_ack_i && time_ack_i))
		else $error("data_ack_o and time_ack_o high in the same cycle");

endmodule

bind spw_tx spw_tx_sva i_sva (
	.pclk_tx    (pclk_tx),
	.enable_tx  (enable_tx),
	.d_i        (d_o),
	.s_i        (s_o),
	.data_ack_i (data_ack_o),
	.time_ack_i (time_ack_o)
);

`default_nettype wire

// File: tb/spw_tx_tb.sv
/* Inputs change on the falling edge. The line is decoded from the first
   DS transition on, and all waits are bounded by the watchdog */
`timescale 1ns/1ps
`default_nettype none
`include "spw_tx_cfg.svh"

module spw_tx_tb;

	localparam int WATCHDOG_NS = 60 * 14 * 20 * 2;
	localparam logic [3:0] P_NULL = 4'b1000;
	localparam logic [3:0] P_FCT = 4'b0100;
	localparam logic [3:0] P_GOT = 4'b0010;
	localparam logic [3:0] P_REQ = 4'b0001;

	logic               pclk_tx;
	logic               enable_tx;
	logic               send_null_i;
	logic               send_fct_i;
	logic               gotfct_i;
	logic               fct_req_i;
	logic               txwrite_i;
	spw_tx_pkg::nchar_u data_i;
	logic               tickin_i;
	logic [7:0]         time_i;
	wire                d_o;
	wire                s_o;
	wire                data_ack_o;
	wire                time_ack_o;

	logic [31:0] lfsr_q = 32'h3eebe94e;
	logic [9:0]  exp_q [$];
	logic [9:0]  acc = '0;
	logic [3:0]  nbit = 4'd0;
	logic [3:0]  clen = 4'd0;
	logic        started = 1'b0;
	logic        esc = 1'b0;
	logic        ds_prev = 1'b0;
	logic        pay_prev = 1'b0;
	int          errors = 0, checks = 0, credit_m = 0, req_cnt = 0, ack_cnt = 0;
	int          null_cnt = 0, fct_cnt = 0, nchar_cnt = 0;

	spw_tx i_spw_tx (.*);

	always #10 pclk_tx = ~pclk_tx;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[6:0], lfsr_q[0]};
		end
	endtask

	// Roughly one word in eight is EOP or EEP
	task automatic pick_word(output spw_tx_pkg::nchar_u w);
		logic [7:0] v;
		rand_bits(3, v);
		if (v[2:0] == 3'd0)
		begin
			rand_bits(1, v);
			w = {1'b1, 7'b0, v[0]};
		end
		else
		begin
			rand_bits(8, v);
			w = {1'b0, v};
		end
	endtask

	task automatic check_nchar(input string name, input spw_tx_pkg::nchar_u got,
		input spw_tx_pkg::nchar_u exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_time(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// Line model
	task automatic match_char(input logic is_time, input logic [8:0] got);
		logic [9:0] e;
		nchar_cnt++;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("Character at %0t was sent without an accept pulse", $time);
		end
		else
		begin
			e = exp_q.pop_front();
			if (e[9] != is_time)
			begin
				errors++;
				$display("Time-code and N-char order broken at %0t", $time);
			end
			else if (is_time)
				check_time("time_i", got[7:0], e[7:0]);
			else
				check_nchar("data_i", got, e[8:0]);
		end
	endtask

	// acc holds parity, flag and payload with the first bit at index 0
	task automatic frame_char();
		check_bit("parity bit", acc[0] ^ pay_prev ^ acc[1], 1'b1);
		pay_prev = acc[1] ? ^acc[3:2] : ^acc[9:2];
		if (esc && acc[1] && acc[3:2] != spw_tx_pkg::CODE_FCT)
		begin
			errors++;
			$display("ESC followed by a bad control code at %0t", $time);
		end
		if (!acc[1])
			match_char(esc, {1'b0, acc[9:2]});
		else if (acc[3:2] == spw_tx_pkg::CODE_FCT)
		begin
			if (esc)
				null_cnt++;
			else
				fct_cnt++;
		end
		else if (acc[3:2] != spw_tx_pkg::CODE_ESC)
			match_char(1'b0, {1'b1, 7'b0, acc[3:2] == spw_tx_pkg::CODE_EEP});
		esc = acc[1] && (acc[3:2] == spw_tx_pkg::CODE_ESC) && !esc;
	endtask

	always @(posedge pclk_tx)
	begin
		int nc;
		if (enable_tx)
		begin
			nc = credit_m;
			if (gotfct_i)
				nc = (nc + `SPW_CREDIT_STEP > `SPW_CREDIT_MAX) ? `SPW_CREDIT_MAX :
					nc + `SPW_CREDIT_STEP;
			if (data_ack_o)
			begin
				check_bit("credit before accept", credit_m != 0, 1'b1);
				check_bit("txwrite_i at data_ack_o", txwrite_i, 1'b1);
				exp_q.push_back({1'b0, data_i});
				ack_cnt++;
				nc--;
			end
			if (time_ack_o)
			begin
				check_bit("tickin_i at time_ack_o", tickin_i, 1'b1);
				exp_q.push_back({2'b10, time_i});
				ack_cnt++;
			end
			credit_m = nc;
			if (fct_req_i)
				req_cnt++;
			if (started || d_o || s_o)
			begin
				if (started)
					check_bit("d_o xor s_o toggle", d_o ^ s_o, ~ds_prev);
				started = 1'b1;
				ds_prev = d_o ^ s_o;
				acc[nbit] = d_o;
				nbit++;
				if (nbit == 4'd2)
					clen = acc[1] ? 4'(`SPW_LEN_CTRL) : 4'(`SPW_LEN_DATA);
				if (nbit == clen)
				begin
					frame_char();
					nbit = 4'd0;
					clen = 4'd0;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	task automatic pulse_inputs(input logic [3:0] sel);
		@(negedge pclk_tx);
		{send_null_i, send_fct_i, gotfct_i, fct_req_i} = sel;
		@(negedge pclk_tx);
		{send_null_i, send_fct_i, gotfct_i, fct_req_i} = 4'b0;
	endtask

	task automatic wait_nulls(input int n);
		int mark;
		mark = null_cnt + n;
		do
			@(negedge pclk_tx);
		while (null_cnt < mark);
	endtask

	task automatic wait_data_ack();
		do
			@(posedge pclk_tx);
		while (!data_ack_o);
		@(negedge pclk_tx);
		txwrite_i = 1'b0;
	endtask

	task automatic send_word(input spw_tx_pkg::nchar_u w);
		@(negedge pclk_tx);
		txwrite_i = 1'b1;
		data_i = w;
		wait_data_ack();
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, DUT stopped responding", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		spw_tx_pkg::nchar_u w;
		logic [7:0]         t;
		int                 mark;
		pclk_tx = 1'b0;
		enable_tx = 1'b0;
		{send_null_i, send_fct_i, gotfct_i, fct_req_i} = 4'b0;
		txwrite_i = 1'b0;
		data_i = '0;
		tickin_i = 1'b0;
		time_i = 8'h00;
		repeat (8) @(negedge pclk_tx);
		check_bit("outputs in reset", d_o | s_o | data_ack_o | time_ack_o, 1'b0);
		repeat (8) @(negedge pclk_tx);
		enable_tx = 1'b1;
		repeat (4) @(negedge pclk_tx);
		check_bit("outputs before start", d_o | s_o | data_ack_o | time_ack_o, 1'b0);

		// Link start with a word already waiting
		pick_word(w);
		txwrite_i = 1'b1;
		data_i = w;
		pulse_inputs(P_NULL);
		pulse_inputs(P_GOT);
		wait_nulls(3);
		check_bit("FCT before send_fct_i", fct_cnt != 0, 1'b0);
		pulse_inputs(P_FCT);
		wait_nulls(3);
		check_bit("owed FCT sent", fct_cnt == `SPW_FCT_INIT, 1'b1);
		check_bit("accept before run", ack_cnt != 0, 1'b0);
		pulse_inputs(P_GOT);
		wait_data_ack();

		pulse_inputs(P_GOT);
		repeat (12)
		begin
			pick_word(w);
			send_word(w);
		end

		// Time-code raised together with a word
		pick_word(w);
		rand_bits(8, t);
		@(negedge pclk_tx);
		txwrite_i = 1'b1;
		data_i = w;
		tickin_i = 1'b1;
		time_i = t;
		do
			@(posedge pclk_tx);
		while (!data_ack_o && !time_ack_o);
		check_bit("time_ack_o", time_ack_o, 1'b1);
		@(negedge pclk_tx);
		tickin_i = 1'b0;
		wait_data_ack();

		repeat (3)
		begin
			pulse_inputs(P_REQ);
			pick_word(w);
			send_word(w);
		end

		// Use up the credit, then hold a word back
		while (credit_m != 0)
		begin
			pick_word(w);
			send_word(w);
		end
		pick_word(w);
		@(negedge pclk_tx);
		txwrite_i = 1'b1;
		data_i = w;
		while (exp_q.size() != 0)
			@(negedge pclk_tx);
		mark = nchar_cnt + fct_cnt + ack_cnt;
		wait_nulls(4);
		check_bit("traffic without credit", nchar_cnt + fct_cnt + ack_cnt != mark, 1'b0);
		pulse_inputs(P_GOT);
		wait_data_ack();

		while (exp_q.size() != 0)
			@(negedge pclk_tx);
		wait_nulls(2);
		check_bit("FCT per request", fct_cnt == `SPW_FCT_INIT + req_cnt, 1'b1);
		$display("Checks %0d, errors %0d, N-chars %0d, FCTs %0d, NULLs %0d",
			checks, errors, nchar_cnt, fct_cnt, null_cnt);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+source
source/spw_tx_pkg.sv
source/spw_char_if.sv
source/spw_tx_sched.sv
source/spw_tx_serializer.sv
source/spw_tx.sv
tb/spw_tx_sva.sv
tb/spw_tx_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the SpaceWire transmitter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module spw_tx_tb -Mdir obj_dir -f compile.f

out=$(./obj_dir/Vspw_tx_tb)
echo "$out"
echo "$out" | grep -qx "Test passed"
